// File: rtl/arith_rs_defines.svh
// ----------------------------------------------------------
// Reservation station sizing macros
// Datapath, ROB tag and control widths, slot count
// ----------------------------------------------------------

`ifndef ARITH_RS_DEFINES_SVH
`define ARITH_RS_DEFINES_SVH

// Datapath
`define RS_XLEN         32  // Operand and result word
`define RS_ROB_IDX_LEN  4   // ROB tag
`define RS_EU_CTL_LEN   4   // Execution unit opcode field

// Station geometry, depth is a power of two
`define RS_DEPTH        4
`define RS_IDX_LEN      2

`endif

// File: rtl/rs_core_pkg.sv
// ----------------------------------------------------------
// Datapath types of the reservation station
// ----------------------------------------------------------

`include "arith_rs_defines.svh"

package rs_core_pkg;

    // Operand and result word
    typedef logic [`RS_XLEN-1:0] xlen_t;

    // ROB entry index used as a producer tag
    typedef logic [`RS_ROB_IDX_LEN-1:0] rob_idx_t;

    // Execution unit opcodes, carried through the station untouched
    typedef enum logic [`RS_EU_CTL_LEN-1:0] {
        EU_ADD = 'd0,
        EU_SUB = 'd1,
        EU_XOR = 'd2,
        EU_AND = 'd3
    } eu_ctl_t;

endpackage

// File: rtl/rs_fsm_pkg.sv
// ----------------------------------------------------------
// Slot state machine encodings
// ----------------------------------------------------------

package rs_fsm_pkg;

    // Slot state
    typedef enum logic [2:0] {
        RS_S_EMPTY        = 3'd0,
        RS_S_RS12_PENDING = 3'd1,  // Both operands waiting
        RS_S_RS1_PENDING  = 3'd2,
        RS_S_RS2_PENDING  = 3'd3,
        RS_S_EX_REQ       = 3'd4,  // Requesting the execution unit
        RS_S_EX_WAIT      = 3'd5,  // Dispatched, result outstanding
        RS_S_COMPLETED    = 3'd6   // Result waiting for the CDB
    } rs_state_t;

    // Register update performed by a slot in the current cycle
    typedef enum logic [3:0] {
        RS_OP_NONE        = 4'd0,
        RS_OP_INSERT      = 4'd1,
        RS_OP_INSERT_RS1  = 4'd2,  // Insert, rs1 taken from result bus
        RS_OP_INSERT_RS2  = 4'd3,  // Insert, rs2 taken from result bus
        RS_OP_INSERT_RS12 = 4'd4,
        RS_OP_SAVE_RS1    = 4'd5,
        RS_OP_SAVE_RS2    = 4'd6,
        RS_OP_SAVE_RS12   = 4'd7,
        RS_OP_SAVE_RES    = 4'd8
    } rs_op_t;

endpackage

// File: rtl/rs_prio_enc.sv
// ----------------------------------------------------------
// Priority encoder, lowest set line wins
// ----------------------------------------------------------

`timescale 1ns/1ps

module rs_prio_enc #(
    parameter  int unsigned N       = 4,
    localparam int unsigned IDX_LEN = (N > 1) ? $clog2(N) : 1
) (
    input  logic [N-1:0]       lines_i,
    output logic [IDX_LEN-1:0] enc_o,
    output logic               valid_o
);

    // Scan from the top so the lowest set line is written last
    always_comb begin : p_encode
        enc_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o = IDX_LEN'(i);
            end
        end
    end

    assign valid_o = |lines_i;  // Any request present

endmodule

// File: rtl/rs_entry.sv
// ----------------------------------------------------------
// Reservation station slot
// State machine, operand wakeup and result storage
// ----------------------------------------------------------

`timescale 1ns/1ps

module rs_entry (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Strobes from the slot selectors
    input  logic                  insert_i,
    input  logic                  dispatch_i,
    input  logic                  remove_i,

    // Issue stage
    input  rs_core_pkg::eu_ctl_t  issue_eu_ctl_i,
    input  logic                  issue_rs1_ready_i,
    input  rs_core_pkg::rob_idx_t issue_rs1_tag_i,
    input  rs_core_pkg::xlen_t    issue_rs1_value_i,
    input  logic                  issue_rs2_ready_i,
    input  rs_core_pkg::rob_idx_t issue_rs2_tag_i,
    input  rs_core_pkg::xlen_t    issue_rs2_value_i,
    input  rs_core_pkg::rob_idx_t issue_dest_tag_i,

    // Execution unit result bus
    input  logic                  eu_valid_i,
    input  rs_core_pkg::rob_idx_t eu_rob_idx_i,
    input  rs_core_pkg::xlen_t    eu_result_i,

    // Common data bus
    input  logic                  cdb_valid_i,
    input  rs_core_pkg::rob_idx_t cdb_rob_idx_i,
    input  rs_core_pkg::xlen_t    cdb_value_i,

    // Slot contents
    output rs_fsm_pkg::rs_state_t state_o,
    output rs_core_pkg::eu_ctl_t  eu_ctl_o,
    output rs_core_pkg::xlen_t    rs1_value_o,
    output rs_core_pkg::xlen_t    rs2_value_o,
    output rs_core_pkg::rob_idx_t dest_tag_o,
    output rs_core_pkg::xlen_t    result_o
);
    import rs_core_pkg::*;
    import rs_fsm_pkg::*;

    rs_state_t state_q;
    rs_state_t state_d;
    rs_op_t    op;

    eu_ctl_t   eu_ctl_q;
    rob_idx_t  rs1_tag_q;
    xlen_t     rs1_value_q;
    rob_idx_t  rs2_tag_q;
    xlen_t     rs2_value_q;
    rob_idx_t  dest_tag_q;
    xlen_t     result_q;

    // ----------------------------------------------------------
    // Tag matching
    // ----------------------------------------------------------

    logic ins_fwd_rs1;
    logic ins_fwd_rs2;
    logic fwd_rs1_eu;
    logic fwd_rs2_eu;
    logic fwd_rs1;
    logic fwd_rs2;
    logic res_match;

    assign ins_fwd_rs1 = eu_valid_i && (eu_rob_idx_i == issue_rs1_tag_i);
    assign ins_fwd_rs2 = eu_valid_i && (eu_rob_idx_i == issue_rs2_tag_i);
    assign fwd_rs1_eu  = eu_valid_i && (eu_rob_idx_i == rs1_tag_q);
    assign fwd_rs2_eu  = eu_valid_i && (eu_rob_idx_i == rs2_tag_q);
    assign fwd_rs1     = fwd_rs1_eu || (cdb_valid_i && (cdb_rob_idx_i == rs1_tag_q));
    assign fwd_rs2     = fwd_rs2_eu || (cdb_valid_i && (cdb_rob_idx_i == rs2_tag_q));
    assign res_match   = eu_valid_i && (eu_rob_idx_i == dest_tag_q);

    // ----------------------------------------------------------
    // Next state and register operation
    // ----------------------------------------------------------

    // Mealy so that bus values are captured in the cycle they appear
    always_comb begin : p_next_state
        state_d = state_q;
        op      = RS_OP_NONE;
        case (state_q)
            RS_S_EMPTY: begin
                if (insert_i) begin
                    op      = RS_OP_INSERT;
                    state_d = RS_S_EX_REQ;
                    if (!issue_rs1_ready_i && !issue_rs2_ready_i) begin
                        if (ins_fwd_rs1 && ins_fwd_rs2) begin
                            op = RS_OP_INSERT_RS12;
                        end else if (ins_fwd_rs1) begin
                            op      = RS_OP_INSERT_RS1;
                            state_d = RS_S_RS2_PENDING;
                        end else if (ins_fwd_rs2) begin
                            op      = RS_OP_INSERT_RS2;
                            state_d = RS_S_RS1_PENDING;
                        end else begin
                            state_d = RS_S_RS12_PENDING;
                        end
                    end else if (!issue_rs1_ready_i) begin
                        if (ins_fwd_rs1) op = RS_OP_INSERT_RS1;
                        else state_d = RS_S_RS1_PENDING;
                    end else if (!issue_rs2_ready_i) begin
                        if (ins_fwd_rs2) op = RS_OP_INSERT_RS2;
                        else state_d = RS_S_RS2_PENDING;
                    end
                end
            end
            RS_S_RS12_PENDING: begin
                if (fwd_rs1 && fwd_rs2) begin
                    op      = RS_OP_SAVE_RS12;
                    state_d = RS_S_EX_REQ;
                end else if (fwd_rs1) begin
                    op      = RS_OP_SAVE_RS1;
                    state_d = RS_S_RS2_PENDING;
                end else if (fwd_rs2) begin
                    op      = RS_OP_SAVE_RS2;
                    state_d = RS_S_RS1_PENDING;
                end
            end
            RS_S_RS1_PENDING: begin
                if (fwd_rs1) begin
                    op      = RS_OP_SAVE_RS1;
                    state_d = RS_S_EX_REQ;
                end
            end
            RS_S_RS2_PENDING: begin
                if (fwd_rs2) begin
                    op      = RS_OP_SAVE_RS2;
                    state_d = RS_S_EX_REQ;
                end
            end
            RS_S_EX_REQ: if (dispatch_i) state_d = RS_S_EX_WAIT;
            RS_S_EX_WAIT: begin
                if (res_match) begin
                    op      = RS_OP_SAVE_RES;
                    state_d = RS_S_COMPLETED;
                end
            end
            RS_S_COMPLETED: if (remove_i) state_d = RS_S_EMPTY;
            default: state_d = RS_S_EMPTY;  // Unused encoding
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : p_state
        if (!rst_n_i) begin
            state_q <= RS_S_EMPTY;
        end else if (flush_i) begin
            state_q <= RS_S_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------
    // Slot fields
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin : p_fields
        case (op)
            RS_OP_INSERT, RS_OP_INSERT_RS1, RS_OP_INSERT_RS2, RS_OP_INSERT_RS12: begin
                eu_ctl_q    <= issue_eu_ctl_i;
                rs1_tag_q   <= issue_rs1_tag_i;
                rs2_tag_q   <= issue_rs2_tag_i;
                dest_tag_q  <= issue_dest_tag_i;
                rs1_value_q <= (op == RS_OP_INSERT_RS1 || op == RS_OP_INSERT_RS12) ?
                               eu_result_i : issue_rs1_value_i;
                rs2_value_q <= (op == RS_OP_INSERT_RS2 || op == RS_OP_INSERT_RS12) ?
                               eu_result_i : issue_rs2_value_i;
            end
            // Result bus has priority over the CDB
            RS_OP_SAVE_RS1: rs1_value_q <= fwd_rs1_eu ? eu_result_i : cdb_value_i;
            RS_OP_SAVE_RS2: rs2_value_q <= fwd_rs2_eu ? eu_result_i : cdb_value_i;
            RS_OP_SAVE_RS12: begin
                rs1_value_q <= fwd_rs1_eu ? eu_result_i : cdb_value_i;
                rs2_value_q <= fwd_rs2_eu ? eu_result_i : cdb_value_i;
            end
            RS_OP_SAVE_RES: result_q <= eu_result_i;
            default: ;
        endcase
    end

    assign state_o     = state_q;
    assign eu_ctl_o    = eu_ctl_q;
    assign rs1_value_o = rs1_value_q;
    assign rs2_value_o = rs2_value_q;
    assign dest_tag_o  = dest_tag_q;
    assign result_o    = result_q;

endmodule

// File: rtl/arith_rs.sv
// ----------------------------------------------------------
// Arithmetic reservation station
// Slot array with issue, dispatch and CDB selectors
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "arith_rs_defines.svh"

module arith_rs #(
    parameter int unsigned DEPTH = `RS_DEPTH  // Power of two
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Issue stage
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    input  rs_core_pkg::eu_ctl_t  issue_eu_ctl_i,
    input  logic                  issue_rs1_ready_i,
    input  rs_core_pkg::rob_idx_t issue_rs1_tag_i,
    input  rs_core_pkg::xlen_t    issue_rs1_value_i,
    input  logic                  issue_rs2_ready_i,
    input  rs_core_pkg::rob_idx_t issue_rs2_tag_i,
    input  rs_core_pkg::xlen_t    issue_rs2_value_i,
    input  rs_core_pkg::rob_idx_t issue_dest_tag_i,

    // Execution unit
    input  logic                  eu_ready_i,
    input  logic                  eu_valid_i,
    input  rs_core_pkg::rob_idx_t eu_rob_idx_i,
    input  rs_core_pkg::xlen_t    eu_result_i,
    output logic                  eu_valid_o,
    output rs_core_pkg::eu_ctl_t  eu_ctl_o,
    output rs_core_pkg::xlen_t    eu_rs1_o,
    output rs_core_pkg::xlen_t    eu_rs2_o,
    output rs_core_pkg::rob_idx_t eu_rob_idx_o,

    // Common data bus
    input  logic                  cdb_ready_i,
    input  logic                  cdb_valid_i,
    input  rs_core_pkg::rob_idx_t cdb_rob_idx_i,
    input  rs_core_pkg::xlen_t    cdb_value_i,
    output logic                  cdb_valid_o,
    output rs_core_pkg::rob_idx_t cdb_rob_idx_o,
    output rs_core_pkg::xlen_t    cdb_value_o
);
    import rs_core_pkg::*;
    import rs_fsm_pkg::*;

    localparam int unsigned IDX_LEN = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Per-slot contents
    rs_state_t slot_state  [DEPTH];
    eu_ctl_t   slot_eu_ctl [DEPTH];
    xlen_t     slot_rs1    [DEPTH];
    xlen_t     slot_rs2    [DEPTH];
    rob_idx_t  slot_dest   [DEPTH];
    xlen_t     slot_result [DEPTH];

    // Selector lines and winners
    logic [DEPTH-1:0]   empty_lines;
    logic [DEPTH-1:0]   req_lines;
    logic [DEPTH-1:0]   done_lines;
    logic [IDX_LEN-1:0] new_idx;
    logic [IDX_LEN-1:0] ex_idx;
    logic [IDX_LEN-1:0] cdb_idx;

    // Handshakes and per-slot strobes
    logic               insert;
    logic               dispatch;
    logic               remove;
    logic [DEPTH-1:0]   insert_sel;
    logic [DEPTH-1:0]   dispatch_sel;
    logic [DEPTH-1:0]   remove_sel;

    assign insert   = issue_valid_i & issue_ready_o;
    assign dispatch = eu_valid_o & eu_ready_i;
    assign remove   = cdb_valid_o & cdb_ready_i;

    always_comb begin : p_lines
        foreach (slot_state[i]) begin
            empty_lines[i] = (slot_state[i] == RS_S_EMPTY);
            req_lines[i]   = (slot_state[i] == RS_S_EX_REQ);
            done_lines[i]  = (slot_state[i] == RS_S_COMPLETED);
        end
    end

    // Each accepted handshake strobes only the selected slot
    always_comb begin : p_strobes
        for (int i = 0; i < DEPTH; i++) begin
            insert_sel[i]   = insert && (new_idx == IDX_LEN'(i));
            dispatch_sel[i] = dispatch && (ex_idx == IDX_LEN'(i));
            remove_sel[i]   = remove && (cdb_idx == IDX_LEN'(i));
        end
    end

    // ----------------------------------------------------------
    // Slots
    // ----------------------------------------------------------

    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        rs_entry i_entry (
            .clk_i             (clk_i),
            .rst_n_i           (rst_n_i),
            .flush_i           (flush_i),
            .insert_i          (insert_sel[i]),
            .dispatch_i        (dispatch_sel[i]),
            .remove_i          (remove_sel[i]),
            .issue_eu_ctl_i    (issue_eu_ctl_i),
            .issue_rs1_ready_i (issue_rs1_ready_i),
            .issue_rs1_tag_i   (issue_rs1_tag_i),
            .issue_rs1_value_i (issue_rs1_value_i),
            .issue_rs2_ready_i (issue_rs2_ready_i),
            .issue_rs2_tag_i   (issue_rs2_tag_i),
            .issue_rs2_value_i (issue_rs2_value_i),
            .issue_dest_tag_i  (issue_dest_tag_i),
            .eu_valid_i        (eu_valid_i),
            .eu_rob_idx_i      (eu_rob_idx_i),
            .eu_result_i       (eu_result_i),
            .cdb_valid_i       (cdb_valid_i),
            .cdb_rob_idx_i     (cdb_rob_idx_i),
            .cdb_value_i       (cdb_value_i),
            .state_o           (slot_state[i]),
            .eu_ctl_o          (slot_eu_ctl[i]),
            .rs1_value_o       (slot_rs1[i]),
            .rs2_value_o       (slot_rs2[i]),
            .dest_tag_o        (slot_dest[i]),
            .result_o          (slot_result[i])
        );
    end

    // ----------------------------------------------------------
    // Selectors
    // ----------------------------------------------------------

    rs_prio_enc #(.N(DEPTH)) i_new_sel (  // First free slot
        .lines_i (empty_lines),
        .enc_o   (new_idx),
        .valid_o (issue_ready_o)
    );

    rs_prio_enc #(.N(DEPTH)) i_ex_sel (   // Lowest slot wins regardless of age
        .lines_i (req_lines),
        .enc_o   (ex_idx),
        .valid_o (eu_valid_o)
    );

    rs_prio_enc #(.N(DEPTH)) i_cdb_sel (
        .lines_i (done_lines),
        .enc_o   (cdb_idx),
        .valid_o (cdb_valid_o)
    );

    // Output multiplexers
    assign eu_ctl_o      = slot_eu_ctl[ex_idx];
    assign eu_rs1_o      = slot_rs1[ex_idx];
    assign eu_rs2_o      = slot_rs2[ex_idx];
    assign eu_rob_idx_o  = slot_dest[ex_idx];
    assign cdb_rob_idx_o = slot_dest[cdb_idx];
    assign cdb_value_o   = slot_result[cdb_idx];

endmodule

// File: testbench/arith_rs_checker.sv
// ----------------------------------------------------------
// Reset and flush assertions for the reservation station
// ----------------------------------------------------------

`timescale 1ns/1ps

module arith_rs_checker (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic issue_ready_i,  // DUT issue_ready_o
    input  logic ex_valid_i,     // DUT eu_valid_o
    input  logic bcast_valid_i   // DUT cdb_valid_o
);

    int unsigned assert_fails = 0;  // Count of failed assertions

    // All slots empty in the first cycle out of reset
    a_reset_empty : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> issue_ready_i && !ex_valid_i && !bcast_valid_i)
    else begin
        $error("Station not empty after reset release");
        assert_fails++;
    end

    a_flush_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> issue_ready_i && !ex_valid_i && !bcast_valid_i)
    else begin
        $error("Station not empty after flush");
        assert_fails++;
    end

    a_cdb_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(bcast_valid_i))
    else begin
        $error("CDB valid is unknown");
        assert_fails++;
    end

endmodule

// File: testbench/tb_arith_rs.sv
// ----------------------------------------------------------
// Testbench for the arithmetic reservation station
// Random issue against execution unit, producer and scoreboard models
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_arith_rs;
    import rs_core_pkg::*;

    localparam time         CLK_PERIOD = 40ns;
    localparam int unsigned NUM_INSTR  = 400;
    localparam time         TIMEOUT    = NUM_INSTR * 40 * CLK_PERIOD;

    // Scoreboard state of a destination tag
    localparam int S_FREE = 0;
    localparam int S_WAIT = 1;  // In a slot and not yet dispatched
    localparam int S_EXEC = 2;  // Dispatched with result outstanding
    localparam int S_DONE = 3;  // Result returned and not yet broadcast

    logic     clk_i;
    logic     rst_n_i;
    logic     flush_i;
    logic     issue_valid_i;
    logic     issue_ready_o;
    eu_ctl_t  issue_eu_ctl_i;
    logic     issue_rs1_ready_i;
    rob_idx_t issue_rs1_tag_i;
    xlen_t    issue_rs1_value_i;
    logic     issue_rs2_ready_i;
    rob_idx_t issue_rs2_tag_i;
    xlen_t    issue_rs2_value_i;
    rob_idx_t issue_dest_tag_i;
    logic     eu_ready_i;
    logic     eu_valid_i;
    rob_idx_t eu_rob_idx_i;
    xlen_t    eu_result_i;
    logic     eu_valid_o;
    eu_ctl_t  eu_ctl_o;
    xlen_t    eu_rs1_o;
    xlen_t    eu_rs2_o;
    rob_idx_t eu_rob_idx_o;
    logic     cdb_ready_i;
    logic     cdb_valid_i;
    rob_idx_t cdb_rob_idx_i;
    xlen_t    cdb_value_i;
    logic     cdb_valid_o;
    rob_idx_t cdb_rob_idx_o;
    xlen_t    cdb_value_o;

    // Model state
    logic [31:0] seed;
    int unsigned cycle;
    int unsigned issued;
    int unsigned occupied;
    logic        flush_seen;
    int          tag_state [8];
    eu_ctl_t     tag_ctl   [8];
    xlen_t       op_val    [8][2];
    logic        op_known  [8][2];
    rob_idx_t    op_src    [8][2];
    xlen_t       exp_res   [8];
    rob_idx_t    eu_q_tag  [$];  // Execution unit in flight
    xlen_t       eu_q_val  [$];
    int unsigned eu_q_due  [$];
    rob_idx_t    ext_q_tag [$];  // Pending external broadcasts
    int unsigned ext_q_due [$];

    arith_rs i_dut (.*);

    bind arith_rs arith_rs_checker i_checker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_ready_i (issue_ready_o),
        .ex_valid_i    (eu_valid_o),
        .bcast_valid_i (cdb_valid_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        seed = lcg_next(seed);
        return (seed >> 8) % n;
    endfunction

    function automatic xlen_t rand_word();
        seed = lcg_next(seed);
        return seed;
    endfunction

    // Value an external producer broadcasts for its tag
    function automatic xlen_t ext_value(input rob_idx_t tag);
        return lcg_next({28'h0, tag} ^ 32'h5a5a_0066);
    endfunction

    function automatic xlen_t alu_result(input eu_ctl_t ctl, input xlen_t a, input xlen_t b);
        case (ctl)
            EU_ADD:  return a + b;
            EU_SUB:  return a - b;
            EU_XOR:  return a ^ b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Expected operand value as known at insertion time
    task automatic record_operand(input int unsigned t, input int unsigned k, input logic ready,
                                  input rob_idx_t tag, input xlen_t value);
        op_src[t][k]   = tag;
        op_known[t][k] = 1'b1;
        if (ready) begin
            op_val[t][k] = value;
        end else if (tag[3]) begin  // External producer
            op_val[t][k] = ext_value(tag);
            ext_q_tag.push_back(tag);
            ext_q_due.push_back(cycle + rand_below(6));
        end else if (tag_state[tag[2:0]] == S_DONE) begin  // Returned in the insertion cycle
            op_val[t][k] = exp_res[tag[2:0]];
        end else begin
            op_known[t][k] = 1'b0;
        end
    endtask

    // ----------------------------------------------------------
    // Scoreboard evaluated at every rising edge
    // ----------------------------------------------------------

    task automatic observe_edge();
        int unsigned t;

        if (i_dut.i_checker.assert_fails != 0) begin
            $display("Stopping because a checker assertion failed");
            $display("Testbench failed");
            $fatal(1);
        end
        if (flush_seen) begin
            check_equal(eu_valid_o, 1'b0, "eu_valid_o after flush");
            check_equal(cdb_valid_o, 1'b0, "cdb_valid_o after flush");
            check_equal(issue_ready_o, 1'b1, "issue_ready_o after flush");
            flush_seen = 1'b0;
        end
        check_equal(issue_ready_o, occupied != 4, "issue_ready_o against occupied slots");
        if (flush_i) begin  // Flush wins over every handshake
            foreach (tag_state[i]) tag_state[i] = S_FREE;
            occupied = 0;
            eu_q_tag.delete();
            eu_q_val.delete();
            eu_q_due.delete();
            ext_q_tag.delete();
            ext_q_due.delete();
            flush_seen = 1'b1;
            return;
        end
        if (eu_valid_i) begin  // Result completes its slot and wakes consumers
            t = eu_rob_idx_i[2:0];
            tag_state[t] = S_DONE;
            foreach (op_known[j, k]) begin
                if (tag_state[j] == S_WAIT && !op_known[j][k] && op_src[j][k] == eu_rob_idx_i) begin
                    op_val[j][k]   = exp_res[t];
                    op_known[j][k] = 1'b1;
                end
            end
        end
        if (eu_valid_o && eu_ready_i) begin
            check_equal(eu_rob_idx_o[3], 1'b0, "dispatched tag range");
            t = eu_rob_idx_o[2:0];
            check_equal(tag_state[t], S_WAIT, "dispatched tag is waiting");
            check_equal({op_known[t][0], op_known[t][1]}, 2'b11, "dispatched operands resolved");
            check_equal(eu_ctl_o, tag_ctl[t], "eu_ctl_o");
            check_equal(eu_rs1_o, op_val[t][0], "eu_rs1_o");
            check_equal(eu_rs2_o, op_val[t][1], "eu_rs2_o");
            exp_res[t]   = alu_result(tag_ctl[t], op_val[t][0], op_val[t][1]);
            tag_state[t] = S_EXEC;
            eu_q_tag.push_back(eu_rob_idx_o);
            eu_q_val.push_back(alu_result(eu_ctl_o, eu_rs1_o, eu_rs2_o));
            eu_q_due.push_back(cycle + rand_below(5));  // 1 to 5 cycles
        end
        if (cdb_valid_o && cdb_ready_i) begin
            check_equal(cdb_rob_idx_o[3], 1'b0, "broadcast tag range");
            t = cdb_rob_idx_o[2:0];
            check_equal(tag_state[t], S_DONE, "broadcast tag holds a result");
            check_equal(cdb_value_o, exp_res[t], "cdb_value_o");
            tag_state[t] = S_FREE;
            occupied--;
        end
        if (issue_valid_i) begin
            t = issue_dest_tag_i[2:0];
            tag_ctl[t] = issue_eu_ctl_i;
            record_operand(t, 0, issue_rs1_ready_i, issue_rs1_tag_i, issue_rs1_value_i);
            record_operand(t, 1, issue_rs2_ready_i, issue_rs2_tag_i, issue_rs2_value_i);
            tag_state[t] = S_WAIT;
            occupied++;
            issued++;
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus for the next cycle
    // ----------------------------------------------------------

    task automatic drive_next();
        int          pick;
        int          src;
        int unsigned start;
        int unsigned dest;
        int unsigned n;
        logic        ret_valid;
        rob_idx_t    ret_tag;
        logic        ready [2];
        rob_idx_t    tag   [2];
        xlen_t       value [2];

        // Execution unit returns at most one due result per cycle
        pick = -1;
        foreach (eu_q_tag[i]) if (pick < 0 && eu_q_due[i] <= cycle) pick = i;
        ret_valid = (pick >= 0);
        ret_tag   = '0;
        if (ret_valid) begin
            ret_tag = eu_q_tag[pick];
            eu_result_i <= eu_q_val[pick];
            eu_q_tag.delete(pick);
            eu_q_val.delete(pick);
            eu_q_due.delete(pick);
        end else begin
            eu_result_i <= rand_word();
        end
        eu_valid_i   <= ret_valid;
        eu_rob_idx_i <= ret_tag;

        pick = -1;
        foreach (ext_q_tag[i]) if (pick < 0 && ext_q_due[i] <= cycle) pick = i;
        if (pick >= 0) begin
            cdb_valid_i   <= 1'b1;
            cdb_rob_idx_i <= ext_q_tag[pick];
            cdb_value_i   <= ext_value(ext_q_tag[pick]);
            ext_q_tag.delete(pick);
            ext_q_due.delete(pick);
        end else begin
            cdb_valid_i   <= 1'b0;
            cdb_rob_idx_i <= rob_idx_t'(rand_below(16));
            cdb_value_i   <= rand_word();
        end

        issue_valid_i <= 1'b0;
        if (issued < NUM_INSTR && occupied < 4 && rand_below(4) != 0) begin
            dest = rand_below(8);
            while (tag_state[dest] != S_FREE) dest = (dest + 1) % 8;
            foreach (ready[k]) begin
                ready[k] = 1'b1;
                tag[k]   = rob_idx_t'(rand_below(16));
                value[k] = rand_word();
                case (rand_below(6))
                    3, 4: begin
                        ready[k] = 1'b0;
                        tag[k]   = rob_idx_t'(8 + rand_below(8));
                    end
                    5: begin  // Name an in-flight destination
                        src   = -1;
                        start = rand_below(8);
                        for (n = 0; n < 8; n++) begin
                            if (src < 0 && tag_state[(start + n) % 8] inside {S_WAIT, S_EXEC})
                                src = (start + n) % 8;
                        end
                        if (ret_valid && rand_below(2) != 0) src = ret_tag;
                        if (src >= 0) begin
                            ready[k] = 1'b0;
                            tag[k]   = rob_idx_t'(src);
                        end
                    end
                    default: ;
                endcase
            end
            issue_valid_i     <= 1'b1;
            issue_eu_ctl_i    <= eu_ctl_t'(rand_below(4));
            issue_rs1_ready_i <= ready[0];
            issue_rs1_tag_i   <= tag[0];
            issue_rs1_value_i <= value[0];
            issue_rs2_ready_i <= ready[1];
            issue_rs2_tag_i   <= tag[1];
            issue_rs2_value_i <= value[1];
            issue_dest_tag_i  <= rob_idx_t'(dest);
        end

        flush_i     <= (issued < NUM_INSTR) && (rand_below(128) == 0);
        eu_ready_i  <= (rand_below(4) != 0);
        cdb_ready_i <= (rand_below(3) != 0);  // CDB back-pressure
    endtask

    initial begin : p_main
        seed       = 32'd66;
        cycle      = 0;
        issued     = 0;
        occupied   = 0;
        flush_seen = 1'b0;
        foreach (tag_state[i]) tag_state[i] = S_FREE;
        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        flush_i           = 1'b0;
        issue_valid_i     = 1'b0;
        issue_eu_ctl_i    = EU_ADD;
        issue_rs1_ready_i = 1'b0;
        issue_rs1_tag_i   = '0;
        issue_rs1_value_i = '0;
        issue_rs2_ready_i = 1'b0;
        issue_rs2_tag_i   = '0;
        issue_rs2_value_i = '0;
        issue_dest_tag_i  = '0;
        eu_ready_i        = 1'b0;
        eu_valid_i        = 1'b0;
        eu_rob_idx_i      = '0;
        eu_result_i       = '0;
        cdb_ready_i       = 1'b0;
        cdb_valid_i       = 1'b0;
        cdb_rob_idx_i     = '0;
        cdb_value_i       = '0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        while (issued < NUM_INSTR || occupied != 0) begin
            @(posedge clk_i);
            cycle++;
            observe_edge();
            drive_next();
        end
        @(posedge clk_i);
        if (i_dut.i_checker.assert_fails == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Stopping because a checker assertion failed");
            $display("Testbench failed");
            $fatal(1);
        end
    end

    initial begin : p_watchdog
        #(TIMEOUT);
        $display("Timeout, the station stopped completing instructions");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

// File: arith_rs.f
+incdir+rtl
rtl/rs_core_pkg.sv
rtl/rs_fsm_pkg.sv
rtl/rs_prio_enc.sv
rtl/rs_entry.sv
rtl/arith_rs.sv
testbench/arith_rs_checker.sv
testbench/tb_arith_rs.sv
